//--- isa_pkg.sv
// Instruction set definitions for the variable length front end and its length table
package isa_pkg;

  // ====================
  // Widths and types
  // ====================

  // The longest instruction is eight bytes, which sets the aligner output width
  localparam int INS_BYTES = 8;
  localparam int INS_W     = INS_BYTES * 8;
  localparam int ADDR_W    = 32;
  localparam int LEN_W     = 4;
  localparam int OPCODE_W  = 8;

  typedef logic [OPCODE_W-1:0] opcode_t;

  // Byte 0 of an instruction holds the opcode and sits in bits 7:0
  typedef logic [INS_W-1:0]    ins_t;

  typedef logic [ADDR_W-1:0]   addr_t;

  // Byte count of one instruction, always 2, 4, 6 or 8
  typedef logic [LEN_W-1:0]    len_t;

  // ====================
  // Length classes
  // ====================

  localparam len_t LEN_2 = 4'd2;
  localparam len_t LEN_4 = 4'd4;
  localparam len_t LEN_6 = 4'd6;
  localparam len_t LEN_8 = 4'd8;

  // Any opcode the table does not name is a two byte instruction
  localparam len_t LEN_DEFAULT = LEN_2;

  // ====================
  // Opcode table
  // ====================

  // Named opcodes, one or more per length class
  // Length 2
  localparam opcode_t OP_BRK   = 8'h00;
  // Length 4
  localparam opcode_t OP_ADDI  = 8'h04;
  // Length 6
  localparam opcode_t OP_R2    = 8'h02;
  // Length 6
  localparam opcode_t OP_ADDIL = 8'h44;
  // Length 6
  localparam opcode_t OP_JMP   = 8'h20;
  // Length 4
  localparam opcode_t OP_JEQZ  = 8'h26;
  // Length 6
  localparam opcode_t OP_LDO   = 8'h86;
  // Length 4
  localparam opcode_t OP_LDOX  = 8'hA6;
  // Length 4
  localparam opcode_t OP_ENTER = 8'hE8;
  // Length 2
  localparam opcode_t OP_NOP   = 8'hF1;

  // Immediate extension prefixes come in pairs that differ only in bit 0
  // Each value below is the even member of its pair
  // Length 2
  localparam opcode_t OP_EXI8  = 8'h50;
  // Length 4
  localparam opcode_t OP_EXI24 = 8'h52;
  // Length 6
  localparam opcode_t OP_EXI40 = 8'h54;
  // Length 8
  localparam opcode_t OP_EXI56 = 8'h56;
  // Length 8, this one has no partner
  localparam opcode_t OP_EXIM  = 8'h58;

  // Every opcode with a high nibble of D is a six byte instruction
  // Only the high nibble of this value is significant
  localparam opcode_t OP_ROW_D = 8'hD0;

endpackage

//--- fetch_pkg.sv
// Front end geometry for the byte queue between the fetcher and the aligner
package fetch_pkg;

  // ====================
  // Geometry
  // ====================

  // The fetcher delivers aligned words of this many bytes
  localparam int FETCH_BYTES = 8;

  // Depth of the byte queue, two fetch words
  localparam int QUEUE_BYTES = 16;

  // Fetch hold is raised when the queue keeps more than this many bytes
  // So a whole word always fits whenever hold is low
  localparam int HOLD_LEVEL  = QUEUE_BYTES - FETCH_BYTES;

  // Occupancy has to reach QUEUE_BYTES itself, hence the extra state
  localparam int QCOUNT_W    = $clog2(QUEUE_BYTES + 1);

  typedef logic [QCOUNT_W-1:0]      qcount_t;
  typedef logic [FETCH_BYTES*8-1:0] fword_t;

endpackage

//--- ins_length.sv
// Instruction length decoder that maps the opcode at the queue head to a byte count
module ins_length (
  input  isa_pkg::opcode_t opcode,
  output isa_pkg::len_t    len
);

  import isa_pkg::*;

  // ====================
  // Length lookup
  // ====================

  // Purely combinational, the aligner sees the length in the same cycle
  // that the opcode reaches the head of the queue
  // Pattern items carry a ? in the bits that do not matter, so the
  // extension pairs and the D row each take a single line
  always_comb begin
    casez (opcode)
      // Two byte forms
      OP_BRK:   len = LEN_2;
      OP_NOP:   len = LEN_2;

      // Four byte forms with a short immediate or displacement
      OP_ADDI:  len = LEN_4;
      OP_JEQZ:  len = LEN_4;
      OP_LDOX:  len = LEN_4;
      OP_ENTER: len = LEN_4;

      // Six byte forms
      OP_R2:    len = LEN_6;
      OP_ADDIL: len = LEN_6;
      OP_JMP:   len = LEN_6;
      OP_LDO:   len = LEN_6;

      // Immediate extension prefixes
      // Bit 0 only selects which half of the immediate is extended,
      // so both members of a pair have the same length
      {OP_EXI8[7:1], 1'b?}:  len = LEN_2;
      {OP_EXI24[7:1], 1'b?}: len = LEN_4;
      {OP_EXI40[7:1], 1'b?}: len = LEN_6;
      {OP_EXI56[7:1], 1'b?}: len = LEN_8;

      // The full width extension stands alone
      OP_EXIM:  len = LEN_8;

      // The whole D row is six bytes long
      {OP_ROW_D[7:4], 4'b????}: len = LEN_6;

      // Everything the table leaves out is treated as a short instruction
      // this keeps the queue moving even on undefined opcodes
      default:  len = LEN_DEFAULT;
    endcase
  end

  // Note that none of the items above overlap, so their order does not matter
  // The D row pattern covers sixteen opcodes and no named opcode lives in it
  // The extension pairs 50 to 57 are also free of named opcodes
  // OP_EXIM at 58 sits just above the last pair and is matched exactly
  // An empty queue presents opcode 00, which decodes as two bytes
  // The aligner then waits because the occupancy is below that length

endmodule

//--- fetch_buffer.sv
// Byte queue that takes aligned fetch words and releases a variable number of head bytes
module fetch_buffer (
  input  logic               clk,
  input  logic               rst,
  input  logic               flush,
  input  logic               fetch_valid,
  input  fetch_pkg::fword_t  fetch_word,
  input  logic               consume,
  input  isa_pkg::len_t      consume_len,
  output isa_pkg::ins_t      head_bytes,
  output fetch_pkg::qcount_t count,
  output logic               fetch_hold
);

  import isa_pkg::*;
  import fetch_pkg::*;

  // Queue storage as one flat vector, byte 0 is the head
  localparam int QW = QUEUE_BYTES * 8;
  localparam int FW = FETCH_BYTES * 8;

  logic [QW-1:0] q_data;
  logic [QW-1:0] q_shift;
  logic [QW-1:0] wr_data;
  logic [QW-1:0] wr_mask;
  logic [QW-1:0] q_data_nxt;
  qcount_t       rem_len;
  qcount_t       keep_cnt;
  qcount_t       count_nxt;
  logic          take;

  // ====================
  // Write and remove
  // ====================

  // A word is taken only while hold is low and no redirect is under way
  assign take = fetch_valid & ~fetch_hold & ~flush;

  // Bytes leaving the head at this edge
  assign rem_len  = consume ? qcount_t'(consume_len) : '0;
  assign keep_cnt = count - rem_len;

  // The remaining bytes slide toward the head and the new word lands right
  // behind them, hold guarantees that keep_cnt is at most HOLD_LEVEL here
  always_comb begin
    q_shift = q_data >> {rem_len, 3'b000};
    wr_data = {{(QW-FW){1'b0}}, fetch_word} << {keep_cnt, 3'b000};
    wr_mask = {{(QW-FW){1'b0}}, {FW{1'b1}}} << {keep_cnt, 3'b000};
    if (take) begin
      q_data_nxt = (q_shift & ~wr_mask) | (wr_data & wr_mask);
    end else begin
      q_data_nxt = q_shift;
    end
  end

  assign count_nxt = keep_cnt + (take ? qcount_t'(FETCH_BYTES) : '0);

  // ====================
  // State
  // ====================

  // Hold looks at the occupancy after this edge, so it is valid for the next one
  always_ff @(posedge clk) begin
    if (rst) begin
      count      <= '0;
      fetch_hold <= 1'b0;
    end else if (flush) begin
      count      <= '0;
      fetch_hold <= 1'b0;
    end else begin
      count      <= count_nxt;
      fetch_hold <= (count_nxt > qcount_t'(HOLD_LEVEL));
    end
  end

  // Stale bytes past the occupancy are never shown, see the head mask below
  always_ff @(posedge clk) begin
    q_data <= q_data_nxt;
  end

  // Head window for the length decoder and the aligner
  // Bytes past the occupancy read as zero
  always_comb begin
    for (int b = 0; b < INS_BYTES; b++) begin
      head_bytes[b*8 +: 8] = (b < count) ? q_data[b*8 +: 8] : 8'h00;
    end
  end

endmodule

//--- ins_aligner.sv
// Instruction aligner that emits the complete head instruction with its length and PC
module ins_aligner (
  input  logic               clk,
  input  logic               rst,
  input  logic               flush,
  input  isa_pkg::addr_t     flush_pc,
  input  isa_pkg::ins_t      head_bytes,
  input  fetch_pkg::qcount_t count,
  input  isa_pkg::len_t      len,
  output logic               consume,
  output isa_pkg::len_t      consume_len,
  output logic               ins_valid,
  output isa_pkg::ins_t      ins,
  output isa_pkg::len_t      ins_len,
  output isa_pkg::addr_t     ins_pc
);

  import isa_pkg::*;
  import fetch_pkg::*;

  // Address of the instruction at the queue head
  addr_t pc;
  ins_t  ins_masked;
  logic  fire;

  // ====================
  // Issue decision
  // ====================

  // The head instruction is complete once the queue holds all of its bytes
  // A redirect in the same cycle wins and nothing is issued
  assign fire = (count >= qcount_t'(len)) && !flush;

  // The queue drops the instruction at the same edge that it is registered
  assign consume     = fire;
  assign consume_len = len;

  // Bytes at or beyond the length belong to the next instruction
  always_comb begin
    for (int b = 0; b < INS_BYTES; b++) begin
      ins_masked[b*8 +: 8] = (b < len) ? head_bytes[b*8 +: 8] : 8'h00;
    end
  end

  // ====================
  // Control state
  // ====================

  // One pulse per instruction, and the PC tracks the queue head
  always_ff @(posedge clk) begin
    if (rst) begin
      ins_valid <= 1'b0;
      pc        <= '0;
    end else if (flush) begin
      ins_valid <= 1'b0;
      pc        <= flush_pc;
    end else begin
      ins_valid <= fire;
      if (fire) begin
        pc <= pc + addr_t'(len);
      end
    end
  end

  // Output register, held between pulses
  always_ff @(posedge clk) begin
    if (fire) begin
      ins     <= ins_masked;
      ins_len <= len;
      ins_pc  <= pc;
    end
  end

endmodule

//--- fetch_align_top.sv
// Alignment stage top level joining the byte queue, length decoder and aligner
module fetch_align_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              fetch_valid,
  input  fetch_pkg::fword_t fetch_word,
  output logic              fetch_hold,
  input  logic              flush,
  input  isa_pkg::addr_t    flush_pc,
  output logic              ins_valid,
  output isa_pkg::ins_t     ins,
  output isa_pkg::len_t     ins_len,
  output isa_pkg::addr_t    ins_pc
);

  import isa_pkg::*;
  import fetch_pkg::*;

  // Head window and occupancy seen by the aligner
  ins_t    head_bytes;
  qcount_t count;
  // Length of the head instruction
  len_t    len;
  // Removal request back to the queue
  logic    consume;
  len_t    consume_len;

  // ====================
  // Instances
  // ====================

  fetch_buffer u_fetch_buffer (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .fetch_valid (fetch_valid),
    .fetch_word  (fetch_word),
    .consume     (consume),
    .consume_len (consume_len),
    .head_bytes  (head_bytes),
    .count       (count),
    .fetch_hold  (fetch_hold)
  );

  // The opcode is always the first byte at the head
  ins_length u_ins_length (
    .opcode (head_bytes[7:0]),
    .len    (len)
  );

  ins_aligner u_ins_aligner (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .flush_pc    (flush_pc),
    .head_bytes  (head_bytes),
    .count       (count),
    .len         (len),
    .consume     (consume),
    .consume_len (consume_len),
    .ins_valid   (ins_valid),
    .ins         (ins),
    .ins_len     (ins_len),
    .ins_pc      (ins_pc)
  );

endmodule

//--- tb_fetch_align.sv
// Testbench for the alignment stage that checks every issued instruction against a reference stream
module tb_fetch_align;

  import isa_pkg::*;
  import fetch_pkg::*;

  // Upper bound on fetch words over all segments for the watchdog
  localparam int MAX_WORDS  = 160;
  localparam int N_RAND_SEG = 6;

  logic   clk;
  logic   rst;
  logic   fetch_valid;
  fword_t fetch_word;
  logic   fetch_hold;
  logic   flush;
  addr_t  flush_pc;
  logic   ins_valid;
  ins_t   ins;
  len_t   ins_len;
  addr_t  ins_pc;

  // Expected instructions in issue order
  ins_t       exp_ins[$];
  len_t       exp_len[$];
  addr_t      exp_pc[$];
  // Byte stream of the segment being fed, in memory order
  logic [7:0] seg_bytes[$];
  addr_t      cur_pc;
  logic [15:0] lfsr;
  int         n_checked;
  int         hold_cycles;

  fetch_align_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_word  (fetch_word),
    .fetch_hold  (fetch_hold),
    .flush       (flush),
    .flush_pc    (flush_pc),
    .ins_valid   (ins_valid),
    .ins         (ins),
    .ins_len     (ins_len),
    .ins_pc      (ins_pc)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ====================
  // Helpers
  // ====================

  // Fibonacci LFSR with taps 16, 14, 13 and 11
  function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) r = {r[30:0], lfsr_step()};
    return r;
  endfunction

  // Length rule of the opcode table
  function automatic len_t ref_len(input opcode_t op);
    if (op[7:4] == 4'hD) return 4'd6;
    // The four extension pairs grow by two bytes per pair from 2 up to 8
    if (op >= 8'h50 && op <= 8'h57) return len_t'({op[2:1], 1'b0}) + 4'd2;
    case (op)
      OP_EXIM:                             return 4'd8;
      OP_ADDI, OP_JEQZ, OP_LDOX, OP_ENTER: return 4'd4;
      OP_R2, OP_ADDIL, OP_JMP, OP_LDO:     return 4'd6;
      default:                             return 4'd2;
    endcase
  endfunction

  // Named opcodes followed by both members of each extension pair and OP_EXIM
  function automatic opcode_t named_op(input int i);
    case (i)
      0:       return OP_BRK;
      1:       return OP_ADDI;
      2:       return OP_R2;
      3:       return OP_ADDIL;
      4:       return OP_JMP;
      5:       return OP_JEQZ;
      6:       return OP_LDO;
      7:       return OP_LDOX;
      8:       return OP_ENTER;
      9:       return OP_NOP;
      default: return opcode_t'(8'h50 + i - 10);
    endcase
  endfunction

  // A few opcodes that the table does not list
  function automatic opcode_t unlisted_op(input int i);
    case (i)
      0:       return 8'h01;
      1:       return 8'h03;
      2:       return 8'h59;
      3:       return 8'h5F;
      4:       return 8'hCF;
      5:       return 8'hE0;
      default: return 8'hFF;
    endcase
  endfunction

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_drain();
    while (exp_len.size() != 0) @(negedge clk);
  endtask

  // Appends one instruction with random operand bytes to the stream and the expectations
  task automatic add_ins(input opcode_t op);
    ins_t v;
    len_t n;
    n      = ref_len(op);
    v      = '0;
    v[7:0] = op;
    for (int b = 1; b < n; b++) v[b*8 +: 8] = 8'(rand_bits(8));
    for (int b = 0; b < n; b++) seg_bytes.push_back(v[b*8 +: 8]);
    exp_ins.push_back(v);
    exp_len.push_back(n);
    exp_pc.push_back(cur_pc);
    cur_pc += addr_t'(n);
  endtask

  // Short instructions fill the last fetch word of a segment
  task automatic pad_segment();
    while (seg_bytes.size() % FETCH_BYTES != 0) add_ins(OP_NOP);
  endtask

  // Redirect to a random aligned PC and drop the old expectations with the queue
  task automatic start_segment();
    addr_t pc;
    pc          = addr_t'(rand_bits(24)) << 3;
    fetch_valid = 1'b0;
    flush       = 1'b1;
    flush_pc    = pc;
    @(posedge clk);
    exp_ins.delete();
    exp_len.delete();
    exp_pc.delete();
    seg_bytes.delete();
    cur_pc = pc;
    @(negedge clk);
    flush = 1'b0;
  endtask

  // The word stays on the bus with valid high until a cycle where hold is low
  task automatic send_word(input fword_t w);
    fetch_valid = 1'b1;
    fetch_word  = w;
    while (fetch_hold) @(negedge clk);
    @(negedge clk);
    fetch_valid = 1'b0;
  endtask

  // Gaps fall only between words so the last word is followed at once by what comes next
  task automatic feed_words(input int n_words, input bit gaps);
    fword_t w;
    for (int i = 0; i < n_words; i++) begin
      for (int b = 0; b < FETCH_BYTES; b++) w[b*8 +: 8] = seg_bytes[i*FETCH_BYTES + b];
      send_word(w);
      if (gaps && i < n_words - 1) idle(int'(rand_bits(2)));
    end
  endtask

  // ====================
  // Stimulus
  // ====================

  initial begin : stimulus
    int n_words;
    int cut;
    lfsr        = 16'd18980;
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch_word  = '0;
    flush       = 1'b0;
    flush_pc    = '0;
    cur_pc      = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    compare_value("ins_valid", ins_valid, 0);
    compare_value("fetch_hold", fetch_hold, 0);
    // Two byte instructions at full rate fill the queue faster than it drains
    for (int i = 0; i < 80; i++) add_ins(rand_bits(1) ? OP_NOP : OP_BRK);
    feed_words(seg_bytes.size() / FETCH_BYTES, 1'b0);
    wait_drain();
    // Sweep of the whole table, the D row and some unlisted opcodes
    start_segment();
    for (int i = 0; i < 19; i++) add_ins(named_op(i));
    for (int i = 0; i < 16; i++) add_ins({4'hD, 4'(i)});
    for (int i = 0; i < 7; i++) add_ins(unlisted_op(i));
    pad_segment();
    feed_words(seg_bytes.size() / FETCH_BYTES, 1'b1);
    wait_drain();
    // Random streams where every other one is cut short by a redirect in mid flight
    // A cut stream is redirected right after its last word, while the queue still holds it
    for (int s = 0; s < N_RAND_SEG; s++) begin
      start_segment();
      while (seg_bytes.size() < 96) begin
        add_ins(rand_bits(1) ? named_op(rand_bits(5) % 19) : opcode_t'(rand_bits(8)));
      end
      pad_segment();
      n_words = seg_bytes.size() / FETCH_BYTES;
      cut     = (s % 2 == 0) ? 1 + int'(rand_bits(3)) : n_words;
      feed_words(cut, 1'b1);
      if (cut >= n_words) wait_drain();
    end
    wait_drain();
    idle(4);
    if (exp_len.size() != 0 || n_checked == 0 || hold_cycles == 0) begin
      $display("ERROR: run ended with %0d missing, %0d checked and %0d hold cycles",
               exp_len.size(), n_checked, hold_cycles);
      abort_run();
    end else begin
      $display("No errors");
      $finish;
    end
  end

  // ====================
  // Checker
  // ====================

  // Outputs are read at the falling edge, inputs at the rising edge, where each is stable
  // Occupancy is rebuilt from taken words and issued lengths to predict the hold level
  initial begin : monitor
    int   bytes_in;
    int   bytes_out;
    logic hold_seen;
    logic in_reset;
    logic after_flush;
    bytes_in    = 0;
    bytes_out   = 0;
    hold_seen   = 1'b0;
    in_reset    = 1'b1;
    after_flush = 1'b0;
    n_checked   = 0;
    hold_cycles = 0;
    forever begin
      @(negedge clk);
      if (!in_reset) begin
        if (after_flush) compare_value("ins_valid", ins_valid, 0);
        if (ins_valid) begin
          if (exp_len.size() == 0) begin
            $display("ERROR: instruction at pc %h issued with nothing expected, time %0t",
                     ins_pc, $time);
            abort_run();
          end else begin
            compare_value("ins", ins, exp_ins.pop_front());
            compare_value("ins_len", ins_len, exp_len.pop_front());
            compare_value("ins_pc", ins_pc, exp_pc.pop_front());
            bytes_out += ins_len;
            n_checked++;
          end
        end
        compare_value("fetch_hold", fetch_hold,
                      (bytes_in - bytes_out) > (QUEUE_BYTES - FETCH_BYTES));
        if (fetch_hold) hold_cycles++;
      end
      hold_seen = fetch_hold;
      @(posedge clk);
      in_reset    = rst;
      after_flush = flush && !rst;
      if (rst || flush) begin
        bytes_in  = 0;
        bytes_out = 0;
      end else if (fetch_valid && !hold_seen) begin
        bytes_in += FETCH_BYTES;
      end
    end
  end

  // Forty cycles per word covers gaps and hold stalls with room to spare
  initial begin : watchdog
    repeat (MAX_WORDS * 40 + 400) @(posedge clk);
    $display("ERROR: watchdog expired, the stage stopped making progress");
    abort_run();
  end

endmodule

//--- src.f
isa_pkg.sv
fetch_pkg.sv
ins_length.sv
fetch_buffer.sv
ins_aligner.sv
fetch_align_top.sv
tb_fetch_align.sv
